/* uart_pkg.sv */
// types and constants shared by the uart transmitter and its testbench
// byte, counter and parity types, frame state encoding

package uart_pkg;

	// one data byte
	typedef logic [7:0] tx_byte_t;

	// bit position within one frame phase, 0 to 8
	typedef logic [3:0] bit_cnt_t;

	// system clocks within one bit period
	typedef logic [15:0] clk_cnt_t;

	localparam bit_cnt_t DATA_BITS = 4'd8; // data bits per frame

	// parity mode, fixed at build time
	typedef enum logic [1:0] {
		PARITY_NONE, // no parity bit on the line
		PARITY_EVEN, // ones in data plus parity is even
		PARITY_ODD   // ones in data plus parity is odd
	} parity_t;

	// frame sequence of the transmitter
	typedef enum logic [2:0] {
		ST_IDLE,   // line high, waiting for a request
		ST_START,  // one start bit, low
		ST_DATA,   // data bits, lsb first
		ST_PARITY, // skipped without parity
		ST_STOP,   // one or two stop bits, high
		ST_DONE    // single cycle, done pulse
	} tx_state_t;

endpackage

/* uart_bit_timer.sv */
// bit-period timer for the uart transmitter
// counts system clocks, ticks on the last cycle of each bit

`timescale 1ns/1ns

module uart_bit_timer #(
	parameter uart_pkg::clk_cnt_t CLKS_PER_BIT = 16'd16 // at least 2
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic timer_clr, // hold count at zero
	output logic bit_tick   // last cycle of a bit period
);
	import uart_pkg::*;

	localparam clk_cnt_t LAST_CNT     = CLKS_PER_BIT - clk_cnt_t'(1);
	localparam clk_cnt_t PRE_LAST_CNT = CLKS_PER_BIT - clk_cnt_t'(2);

	clk_cnt_t clk_cnt;

	// clock counter, wraps once per bit
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			clk_cnt <= '0;
		end else if (timer_clr || clk_cnt == LAST_CNT) begin
			clk_cnt <= '0;
		end else begin
			clk_cnt <= clk_cnt + clk_cnt_t'(1);
		end
	end

	// registered one cycle early so it lines up with LAST_CNT
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			bit_tick <= 1'b0;
		end else begin
			bit_tick <= !timer_clr && (clk_cnt == PRE_LAST_CNT);
		end
	end

endmodule

/* uart_tx_shifter.sv */
// data shift register for the uart transmitter
// loads one byte, shifts it out lsb first, latches the parity bit

`timescale 1ns/1ns

module uart_tx_shifter #(
	parameter uart_pkg::parity_t PARITY = uart_pkg::PARITY_NONE
) (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  logic               load,       // accepted request
	input  logic               shift,      // end of a data bit
	input  uart_pkg::tx_byte_t tx_data,
	output logic               ser_bit,    // next data bit for the line
	output logic               parity_bit
);
	import uart_pkg::*;

	tx_byte_t shift_reg;
	logic     parity_calc;

	// parity of the incoming byte
	always_comb begin
		case (PARITY)
			PARITY_EVEN: parity_calc = ^tx_data;
			PARITY_ODD:  parity_calc = ~^tx_data;
			default:     parity_calc = 1'b0;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			shift_reg  <= '1;
			parity_bit <= 1'b0;
		end else if (load) begin
			shift_reg  <= tx_data;
			parity_bit <= parity_calc;
		end else if (shift) begin
			// shift right, fill with idle level
			shift_reg <= {1'b1, shift_reg[$bits(tx_byte_t)-1:1]};
		end
	end

	assign ser_bit = shift_reg[0];

endmodule

/* uart_tx_ctrl.sv */
// frame control for the uart transmitter
// state machine, bit counter, registered serial line, busy and done

`timescale 1ns/1ns

module uart_tx_ctrl #(
	parameter uart_pkg::bit_cnt_t STOP_BITS = 4'd1, // 1 or 2
	parameter uart_pkg::parity_t  PARITY    = uart_pkg::PARITY_NONE
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic tx_req,     // one-cycle request strobe
	input  logic bit_tick,   // last cycle of a bit period
	input  logic ser_bit,
	input  logic parity_bit,
	output logic timer_clr,
	output logic load,
	output logic shift,
	output logic tx,         // serial line
	output logic tx_busy,
	output logic tx_done
);
	import uart_pkg::*;

	tx_state_t state;
	tx_state_t state_nxt;
	bit_cnt_t  bit_cnt;    // bits finished in this phase
	bit_cnt_t  phase_bits; // length of this phase
	logic      phase_end;

	// number of bits in the current phase
	always_comb begin
		case (state)
			ST_DATA: phase_bits = DATA_BITS;
			ST_STOP: phase_bits = STOP_BITS;
			default: phase_bits = bit_cnt_t'(1); // start and parity
		endcase
	end

	// tick that completes the last bit of the phase
	assign phase_end = bit_tick && (bit_cnt == phase_bits - bit_cnt_t'(1));

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (tx_req)
					state_nxt = ST_START;
			end
			ST_START: begin
				if (phase_end)
					state_nxt = ST_DATA;
			end
			ST_DATA: begin
				if (phase_end)
					state_nxt = (PARITY == PARITY_NONE) ? ST_STOP : ST_PARITY;
			end
			ST_PARITY: begin
				if (phase_end)
					state_nxt = ST_STOP;
			end
			ST_STOP: begin
				if (phase_end)
					state_nxt = ST_DONE;
			end
			ST_DONE: state_nxt = ST_IDLE; // one cycle only
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// bit counter, restarts at every phase boundary
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			bit_cnt <= '0;
		end else if (timer_clr || phase_end) begin
			bit_cnt <= '0;
		end else if (bit_tick) begin
			bit_cnt <= bit_cnt + bit_cnt_t'(1);
		end
	end

	// line driver, one cycle behind the state
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx <= 1'b1;
		end else begin
			case (state)
				ST_START:  tx <= 1'b0;
				ST_DATA:   tx <= ser_bit;
				ST_PARITY: tx <= parity_bit;
				default:   tx <= 1'b1; // idle, stop, done
			endcase
		end
	end

	assign timer_clr = (state == ST_IDLE);
	assign load      = (state == ST_IDLE) && tx_req; // requests while busy are dropped
	assign shift     = (state == ST_DATA) && bit_tick;
	assign tx_busy   = (state != ST_IDLE);
	assign tx_done   = (state == ST_DONE);

endmodule

/* uart_tx_top.sv */
// top level of the uart transmitter
// frame controller, bit-period timer and data shifter

`timescale 1ns/1ns

module uart_tx_top #(
	parameter uart_pkg::clk_cnt_t CLKS_PER_BIT = 16'd434, // 50 MHz at 115200 baud
	parameter uart_pkg::bit_cnt_t STOP_BITS    = 4'd1,
	parameter uart_pkg::parity_t  PARITY       = uart_pkg::PARITY_NONE
) (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  uart_pkg::tx_byte_t tx_data,
	input  logic               tx_req,
	output logic               tx,
	output logic               tx_busy,
	output logic               tx_done
);

	logic timer_clr;
	logic bit_tick;
	logic load;
	logic shift;
	logic ser_bit;
	logic parity_bit;

	uart_tx_ctrl #(
		.STOP_BITS (STOP_BITS),
		.PARITY    (PARITY)
	) u_ctrl (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_req     (tx_req),
		.bit_tick   (bit_tick),
		.ser_bit    (ser_bit),
		.parity_bit (parity_bit),
		.timer_clr  (timer_clr),
		.load       (load),
		.shift      (shift),
		.tx         (tx),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done)
	);

	uart_bit_timer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.timer_clr (timer_clr),
		.bit_tick  (bit_tick)
	);

	uart_tx_shifter #(
		.PARITY (PARITY)
	) u_shifter (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.load       (load),
		.shift      (shift),
		.tx_data    (tx_data),
		.ser_bit    (ser_bit),
		.parity_bit (parity_bit)
	);

endmodule

/* uart_tx_assertions.sv */
// concurrent checks on the uart frame controller
// single-cycle done pulse, busy level, idle line level

`timescale 1ns/1ns

module uart_tx_assertions (
	input logic                sys_clk,
	input logic                sys_rst_n,
	input uart_pkg::tx_state_t state,
	input logic                tx,
	input logic                tx_busy,
	input logic                tx_done
);
	import uart_pkg::*;

	// done lasts one cycle only
	done_single_cycle: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done
	) else $error("tx_done high on two consecutive cycles");

	// busy holds through the frame until the done cycle
	busy_until_done: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_busy && !tx_done) |=> tx_busy
	) else $error("tx_busy dropped before the done pulse");

	// line rests high in idle
	idle_line_high: assert property (
		@(posedge sys_clk) disable iff (!sys_rst_n)
		(state == ST_IDLE) |-> tx
	) else $error("tx low while idle");

endmodule

/* tb_uart_tx_top.sv */
// testbench for the uart transmitter top level
// lfsr stimulus, mid-bit frame decoder, compare tasks and timeout

`timescale 1ns/1ns

module tb_uart_tx_top;
	import uart_pkg::*;

	localparam clk_cnt_t CLKS_PER_BIT   = 16'd16;
	localparam bit_cnt_t STOP_BITS      = 4'd2;
	localparam int       NUM_FRAMES     = 40;
	localparam int       TIMEOUT_CYCLES = 60 * (12 * 16 + 20); // 60 frames with margin

	logic     sys_clk = 1'b0;
	logic     sys_rst_n;
	tx_byte_t tx_data;
	logic     tx_req;
	logic     tx;
	logic     tx_busy;
	logic     tx_done;

	logic [31:0] lfsr_state = 32'h24d2_bf02;
	tx_byte_t    exp_q[$];        // bytes accepted by the DUT
	int          idle_reqs = 0;
	int          frames_decoded = 0;
	int          done_cycles = 0;
	int          cycle_cnt = 0;

	uart_tx_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.STOP_BITS    (STOP_BITS),
		.PARITY       (PARITY_EVEN)
	) uut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (tx_data),
		.tx_req    (tx_req),
		.tx        (tx),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done)
	);

	bind uart_tx_ctrl uart_tx_assertions u_assertions (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.state     (state),
		.tx        (tx),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done)
	);

	always #5 sys_clk = ~sys_clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_byte(input string name, input tx_byte_t exp, input tx_byte_t act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected 0x%02h, actual 0x%02h", name, exp, act);
			$display("Finished with errors");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
			$display("Finished with errors");
			$fatal(1, "bit mismatch");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
			$display("Finished with errors");
			$fatal(1, "count mismatch");
		end
	endtask

	// one request strobe, predicted from tx_busy at this edge
	task automatic send_request(input tx_byte_t data);
		tx_data = data;
		tx_req  = 1'b1;
		if (!tx_busy) begin
			exp_q.push_back(data);
			idle_reqs++;
		end
		@(negedge sys_clk);
		tx_req = 1'b0;
	endtask

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: no end of test after %0d cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$fatal(1, "timeout");
		end
	end

	always @(negedge sys_clk) begin
		if (sys_rst_n && tx_done)
			done_cycles++; // cycles, so a long pulse shows up
	end

	// frame decoder, samples tx in the middle of each bit
	initial begin : frame_model
		tx_byte_t exp_byte;
		tx_byte_t got_byte;
		int       wait_cnt;
		wait (sys_rst_n === 1'b1);
		forever begin
			@(negedge tx);
			if (exp_q.size() == 0) begin
				$display("frame started on tx without an accepted request");
				$display("Finished with errors");
				$fatal(1, "extra frame");
			end else begin
				exp_byte = exp_q.pop_front();
				repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);
				check_bit("start bit", 1'b0, tx);
				for (int b = 0; b < DATA_BITS; b++) begin
					repeat (CLKS_PER_BIT) @(negedge sys_clk);
					got_byte[b] = tx;
				end
				check_byte("data byte", exp_byte, got_byte);
				repeat (CLKS_PER_BIT) @(negedge sys_clk);
				// odd count of ones needs a one to make the total even
				check_bit("even parity", ($countones(exp_byte) % 2) == 1, tx);
				for (int s = 0; s < STOP_BITS; s++) begin
					repeat (CLKS_PER_BIT) @(negedge sys_clk);
					check_bit("stop bit", 1'b1, tx);
				end
				wait_cnt = 0;
				@(negedge sys_clk);
				while (!tx_done && wait_cnt < 2 * CLKS_PER_BIT) begin
					@(negedge sys_clk);
					wait_cnt++;
				end
				check_bit("done pulse", 1'b1, tx_done);
				@(negedge sys_clk);
				check_bit("done width", 1'b0, tx_done);
				check_bit("busy between frames", 1'b0, tx_busy);
				check_bit("line between frames", 1'b1, tx);
				frames_decoded++;
			end
		end
	end

	initial begin : stimulus
		logic [31:0] r;
		sys_rst_n = 1'b0;
		tx_req    = 1'b0;
		tx_data   = '0;
		repeat (8) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_bit("reset line", 1'b1, tx);
		check_bit("reset busy", 1'b0, tx_busy);
		check_bit("reset done", 1'b0, tx_done);
		for (int i = 0; i < NUM_FRAMES; i++) begin
			while (tx_busy)
				@(negedge sys_clk);
			random_bits(4, r);
			repeat (r[3:0]) @(negedge sys_clk); // idle gap
			random_bits(8, r);
			send_request(r[7:0]);
			random_bits(1, r);
			if (r[0]) begin
				// second strobe inside the frame, must be dropped
				random_bits(7, r);
				repeat (r[6:0]) @(negedge sys_clk);
				random_bits(8, r);
				send_request(r[7:0]);
			end
		end
		while (tx_busy)
			@(negedge sys_clk);
		repeat (3 * CLKS_PER_BIT) @(negedge sys_clk); // no stray frame afterwards
		check_count("decoded frames", idle_reqs, frames_decoded);
		check_count("done cycles", frames_decoded, done_cycles);
		check_count("pending bytes", 0, exp_q.size());
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* uart_tx_top.f */
uart_pkg.sv
uart_bit_timer.sv
uart_tx_shifter.sv
uart_tx_ctrl.sv
uart_tx_top.sv
uart_tx_assertions.sv
tb_uart_tx_top.sv

/* Bender.yml */
package:
  name: uart_tx

sources:
  - uart_pkg.sv
  - uart_bit_timer.sv
  - uart_tx_shifter.sv
  - uart_tx_ctrl.sv
  - uart_tx_top.sv
  - target: test
    files:
      - uart_tx_assertions.sv
      - tb_uart_tx_top.sv
